/* src.f */
design/rv_isa_pkg.sv
design/core_cfg_pkg.sv
design/inst_decoder.sv
design/imm_gen.sv
design/alu_unit.sv
design/register_file.sv
design/pc_unit.sv
design/rv_core.sv
verif/tb_rv_core.sv

/* run.sh */
#!/bin/sh
# Build and run the rv_core testbench with Verilator.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f src.f --top-module tb_rv_core -o sim_tb_rv_core
if [ $? -ne 0 ]; then
  echo "build failed"
  exit 1
fi

output=$(./obj_dir/sim_tb_rv_core)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
  echo "simulation returned status $status"
  exit 1
fi

if echo "$output" | grep -q "^Regression passed$"; then
  exit 0
fi
exit 1

/* verif/tb_rv_core.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_rv_core;
  import rv_isa_pkg::*;
  import core_cfg_pkg::*;

  localparam logic [3:0] k_alu = 4'd0, k_ldsd = 4'd1, k_x0 = 4'd2, k_beq = 4'd3, k_bne = 4'd4;
  localparam logic [3:0] k_jal = 4'd5, k_jalr = 4'd6, k_lui = 4'd7, k_auipc = 4'd8;
  localparam int n_random = 8;

  typedef struct packed {
    logic [3:0]  kind;
    logic [2:0]  f3;
    logic        alt;
    logic [11:0] a;
    logic [11:0] b;
    logic        use_imm;
  } row_t;

  logic clk, rst_n;
  logic [xlen-1:0] imem_addr, dmem_addr, dmem_wdata, dmem_rdata, pc, imem_idx;
  logic [31:0] imem_rdata;
  logic dmem_wen, dmem_ren, halted;
  logic [31:0] imem [0:15];
  logic [xlen-1:0] dmem [0:63];
  row_t rows[$];
  int halt_idx;
  int seed_ret;

  rv_core dut (.clk, .rst_n, .imem_addr, .imem_rdata, .dmem_addr, .dmem_wdata, .dmem_wen,
    .dmem_ren, .dmem_rdata, .pc, .halted);

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  assign imem_idx   = (imem_addr - pc_init) >> 2;
  assign imem_rdata = (imem_idx < 16) ? imem[imem_idx[3:0]] : 32'h0; // zero decodes as no-op.
  assign dmem_rdata = dmem_ren ? dmem[dmem_addr[8:3]] : '0; // data only answers a read.

  function automatic logic [xlen-1:0] fill_word(input int i);
    return 64'hc0de_0000_0000_0000 ^ (64'(i) * 64'h0101_0101_0101);
  endfunction

  always @(posedge clk) begin
    if (!rst_n) begin
      for (int i = 0; i < 64; i++) dmem[i] <= fill_word(i); // every slot differs from zero.
    end else if (dmem_wen) begin
      dmem[dmem_addr[8:3]] <= dmem_wdata;
    end
  end

  function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                        input logic [2:0] f3, input logic [4:0] rd,
                                        input logic [6:0] op);
    return {imm, rs1, f3, rd, op};
  endfunction

  function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                        input logic [4:0] rs1, input logic [2:0] f3,
                                        input logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, op_reg};
  endfunction

  function automatic logic [31:0] enc_s(input logic [11:0] imm, input logic [4:0] rs2);
    return {imm[11:5], rs2, 5'd0, f3_dword, imm[4:0], op_store};
  endfunction

  function automatic logic [31:0] enc_b(input logic [12:0] imm, input logic [2:0] f3);
    return {imm[12], imm[10:5], 5'd2, 5'd1, f3, imm[4:1], imm[11], op_branch};
  endfunction

  function automatic logic [31:0] enc_j(input logic [20:0] imm, input logic [4:0] rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, op_jal};
  endfunction

  // reference behavior of the integer operations on 64-bit values.
  function automatic logic [xlen-1:0] alu_model(input logic [2:0] f3, input logic alt,
                                                input logic [xlen-1:0] a,
                                                input logic [xlen-1:0] b);
    logic [5:0] sh;
    sh = b[5:0];
    case (f3)
      3'd0: return alt ? a - b : a + b;
      3'd1: return a << sh;
      3'd2: return ($signed(a) < $signed(b)) ? 64'd1 : 64'd0;
      3'd3: return (a < b) ? 64'd1 : 64'd0;
      3'd4: return a ^ b;
      3'd5: return alt ? 64'($signed(a) >>> sh) : a >> sh;
      3'd6: return a | b;
      default: return a & b;
    endcase
  endfunction

  task automatic fail_run(input string why);
    $display("%s", why);
    $display("Regression failed");
    $fatal(1);
  endtask

  task automatic check_xlen(input string name, input logic [xlen-1:0] exp,
                            input logic [xlen-1:0] act);
    if (act !== exp) fail_run($sformatf("mismatch %s expected %h actual %h", name, exp, act));
  endtask

  task automatic check_pc(input string name, input logic [xlen-1:0] exp,
                          input logic [xlen-1:0] act);
    if (act !== exp) fail_run($sformatf("mismatch %s expected %h actual %h", name, exp, act));
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    if (act !== exp) fail_run($sformatf("mismatch %s expected %h actual %h", name, exp, act));
  endtask

  function automatic logic [xlen-1:0] sext12(input logic [11:0] v);
    return {{(xlen-12){v[11]}}, v};
  endfunction

  // writes the program for one row and returns the value it should store.
  task automatic build_program(input row_t r, input int slot, output logic [xlen-1:0] exp);
    logic [11:0] off;
    logic [11:0] imm2;
    logic [19:0] u20;
    off  = 12'(slot * 8);
    u20  = {r.a, r.b[7:0]};
    for (int i = 0; i < 16; i++) imem[i] = enc_i(12'd0, 5'd0, f3_add_sub, 5'd0, op_imm);
    imem[0] = enc_i(r.a, 5'd0, f3_add_sub, 5'd1, op_imm);
    imem[1] = enc_i(r.b, 5'd0, f3_add_sub, 5'd2, op_imm);
    halt_idx = 4;
    case (r.kind)
      k_alu: begin
        if (r.use_imm) begin
          imm2 = (r.f3 == f3_sll || r.f3 == f3_srl_sra) ?
                 {(r.alt && r.f3 == f3_srl_sra) ? 6'b010000 : 6'b0, r.b[5:0]} : r.b;
          imem[2] = enc_i(imm2, 5'd1, r.f3, 5'd3, op_imm);
          exp = alu_model(r.f3, r.alt && r.f3 == f3_srl_sra, sext12(r.a), sext12(imm2));
        end else begin
          imem[2] = enc_r((r.alt && (r.f3 == 3'd0 || r.f3 == 3'd5)) ? f7_alt : f7_base,
                          5'd2, 5'd1, r.f3, 5'd3);
          exp = alu_model(r.f3, r.alt && (r.f3 == 3'd0 || r.f3 == 3'd5),
                          sext12(r.a), sext12(r.b));
        end
        imem[3] = enc_s(off, 5'd3);
      end
      k_ldsd: begin
        imem[2] = enc_s(12'd504, 5'd1); // slot 63 is scratch.
        imem[3] = enc_i(12'd504, 5'd0, f3_dword, 5'd3, op_load);
        imem[4] = enc_s(off, 5'd3);
        halt_idx = 5;
        exp = sext12(r.a);
      end
      k_x0: begin
        imem[2] = enc_i(r.a, 5'd0, f3_add_sub, 5'd0, op_imm);
        imem[3] = enc_s(off, 5'd0);
        exp = '0;
      end
      k_beq, k_bne: begin
        imem[2] = enc_i(12'd1, 5'd0, f3_add_sub, 5'd3, op_imm);
        imem[3] = enc_b(13'd8, (r.kind == k_beq) ? f3_beq : f3_bne);
        imem[4] = enc_i(12'd2, 5'd0, f3_add_sub, 5'd3, op_imm); // marker when not taken.
        imem[5] = enc_s(off, 5'd3);
        halt_idx = 6;
        exp = (r.kind == k_beq) == (r.a == r.b) ? 64'd1 : 64'd2;
      end
      k_jal: begin
        imem[2] = enc_j(21'd8, 5'd3);
        imem[3] = enc_i(12'd7, 5'd0, f3_add_sub, 5'd3, op_imm);
        imem[4] = enc_s(off, 5'd3);
        halt_idx = 5;
        exp = pc_init + 64'd12;
      end
      k_jalr: begin
        imem[2] = {20'd0, 5'd4, op_auipc};
        imem[3] = enc_i(12'd12, 5'd4, 3'd0, 5'd3, op_jalr); // lands at index 5.
        imem[4] = enc_i(12'd7, 5'd0, f3_add_sub, 5'd3, op_imm);
        imem[5] = enc_s(off, 5'd3);
        halt_idx = 6;
        exp = pc_init + 64'd16;
      end
      k_lui: begin
        imem[2] = {u20, 5'd3, op_lui};
        imem[3] = enc_s(off, 5'd3);
        exp = {{(xlen-32){u20[19]}}, u20, 12'd0};
      end
      default: begin
        imem[2] = {u20, 5'd3, op_auipc};
        imem[3] = enc_s(off, 5'd3);
        exp = pc_init + 64'd8 + {{(xlen-32){u20[19]}}, u20, 12'd0};
      end
    endcase
    imem[halt_idx] = ebreak_inst;
  endtask

  task automatic apply_row(input row_t r, input int slot);
    logic [xlen-1:0] exp;
    build_program(r, slot, exp);
    rst_n = 1'b0;
    repeat (5) @(posedge clk);
    #2;
    check_pc("pc", pc_init, pc);
    check_bit("halted", 1'b0, halted);
    rst_n = 1'b1;
    while (!halted) begin
      @(posedge clk);
      #2;
    end
    check_xlen($sformatf("dmem[%0d]", slot), exp, dmem[slot]);
    repeat (10) begin
      @(posedge clk);
      #2;
      check_pc("pc", pc_init + 64'(halt_idx * inst_len), pc);
      check_bit("halted", 1'b1, halted);
      check_bit("dmem_wen", 1'b0, dmem_wen);
      check_bit("dmem_ren", 1'b0, dmem_ren);
    end
  endtask

  initial begin
    rst_n = 1'b0;
    seed_ret = $urandom(32'hc777);
    rows = '{
      '{k_alu, 3'd0, 1'b0, 12'd5,   12'd7,   1'b0}, '{k_alu, 3'd0, 1'b1, 12'd3,   12'hffb, 1'b0},
      '{k_alu, 3'd1, 1'b0, 12'h7ff, 12'd33,  1'b0}, '{k_alu, 3'd2, 1'b0, 12'hffd, 12'd2,   1'b0},
      '{k_alu, 3'd3, 1'b0, 12'hffd, 12'd2,   1'b0}, '{k_alu, 3'd4, 1'b0, 12'h5a5, 12'h0ff, 1'b0},
      '{k_alu, 3'd5, 1'b0, 12'hfff, 12'd4,   1'b0}, '{k_alu, 3'd5, 1'b1, 12'h800, 12'd7,   1'b0},
      '{k_alu, 3'd6, 1'b0, 12'h0f0, 12'h00f, 1'b0}, '{k_alu, 3'd7, 1'b0, 12'hff0, 12'h13c, 1'b0},
      '{k_alu, 3'd0, 1'b0, 12'd9,   12'hff0, 1'b1}, '{k_alu, 3'd2, 1'b0, 12'hff0, 12'd1,   1'b1},
      '{k_alu, 3'd3, 1'b0, 12'd4,   12'hfff, 1'b1}, '{k_alu, 3'd4, 1'b0, 12'h123, 12'hfff, 1'b1},
      '{k_alu, 3'd6, 1'b0, 12'h100, 12'h00c, 1'b1}, '{k_alu, 3'd7, 1'b0, 12'hfff, 12'h0f0, 1'b1},
      '{k_alu, 3'd1, 1'b0, 12'hfff, 12'd63,  1'b1}, '{k_alu, 3'd5, 1'b0, 12'hfff, 12'd60,  1'b1},
      '{k_alu, 3'd5, 1'b1, 12'h801, 12'd9,   1'b1}, '{k_ldsd, 3'd0, 1'b0, 12'h9ab, 12'd0,  1'b0},
      '{k_x0,  3'd0, 1'b0, 12'h055, 12'd0,   1'b0}, '{k_beq, 3'd0, 1'b0, 12'd6,   12'd6,   1'b0},
      '{k_beq, 3'd0, 1'b0, 12'd6,   12'd5,   1'b0}, '{k_bne, 3'd0, 1'b0, 12'd6,   12'd5,   1'b0},
      '{k_bne, 3'd0, 1'b0, 12'd6,   12'd6,   1'b0}, '{k_jal, 3'd0, 1'b0, 12'd0,   12'd0,   1'b0},
      '{k_jalr, 3'd0, 1'b0, 12'd0,  12'd0,   1'b0}, '{k_lui, 3'd0, 1'b0, 12'h876, 12'h054, 1'b0},
      '{k_auipc, 3'd0, 1'b0, 12'h012, 12'h345, 1'b0}
    };
    for (int i = 0; i < n_random; i++) begin
      rows.push_back(row_t'{k_alu, 3'($urandom), 1'($urandom), 12'($urandom), 12'($urandom),
                            1'($urandom)});
    end
    for (int i = 0; i < rows.size(); i++) apply_row(rows[i], i);
    $display("Regression passed");
    $finish;
  end

  initial begin
    #1;
    #(((rows.size() + 4) * 40 + 5) * 40);
    fail_run("timeout: the core never halted within the time limit");
  end

endmodule

`default_nettype wire

/* design/rv_core.sv */
`timescale 1ns/1ps
`default_nettype none

module rv_core (
  input  logic                          clk,
  input  logic                          rst_n,
  output logic [core_cfg_pkg::xlen-1:0] imem_addr,
  input  logic [31:0]                   imem_rdata,
  output logic [core_cfg_pkg::xlen-1:0] dmem_addr,
  output logic [core_cfg_pkg::xlen-1:0] dmem_wdata,
  output logic                          dmem_wen,
  output logic                          dmem_ren,
  input  logic [core_cfg_pkg::xlen-1:0] dmem_rdata,
  output logic [core_cfg_pkg::xlen-1:0] pc,
  output logic                          halted
);
  import rv_isa_pkg::*;
  import core_cfg_pkg::*;

  logic [31:0]           inst;
  logic [reg_addr_w-1:0] rs1, rs2, rd;
  logic [xlen-1:0]       imm, rs1_val, rs2_val, alu_res, snpc, wb_data;
  logic                  run, reg_wen, is_ebreak, br_taken;
  alu_op_e               alu_op;
  a_sel_e                a_sel;
  b_sel_e                b_sel;
  wb_sel_e               wb_sel;
  pc_sel_e               pc_sel;
  imm_sel_e              imm_sel;

  assign imem_addr = pc;
  assign inst      = imem_rdata; // fetch answers in the same cycle.

  assign rs1 = inst[19:15];
  assign rs2 = inst[24:20];
  assign rd  = inst[11:7];

  pc_unit u_pc (.clk, .rst_n, .pc_sel, .is_ebreak, .br_taken, .imm, .alu_res,
    .pc, .snpc, .run, .halted);

  inst_decoder u_dec (.inst, .run, .alu_op, .a_sel, .b_sel, .wb_sel, .pc_sel,
    .imm_sel, .reg_wen, .mem_wen(dmem_wen), .mem_ren(dmem_ren), .is_ebreak);

  imm_gen u_imm (.inst, .imm_sel, .imm);

  register_file u_rf (.clk, .rst_n, .rs1_addr(rs1), .rs2_addr(rs2), .rd_addr(rd),
    .wen(reg_wen), .wdata(wb_data), .rs1_val, .rs2_val);

  alu_unit u_alu (.a_sel, .b_sel, .alu_op, .rs1_val, .rs2_val, .pc, .imm,
    .alu_res, .br_taken);

  assign dmem_addr  = alu_res;
  assign dmem_wdata = rs2_val;

  // jumps write the return address, loads the memory word.
  assign wb_data = (wb_sel == wb_mem)  ? dmem_rdata :
                   (wb_sel == wb_snpc) ? snpc : alu_res;

endmodule

`default_nettype wire

/* design/pc_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module pc_unit (
  input  logic                          clk,
  input  logic                          rst_n,
  input  rv_isa_pkg::pc_sel_e           pc_sel,
  input  logic                          is_ebreak,
  input  logic                          br_taken,
  input  logic [core_cfg_pkg::xlen-1:0] imm,
  input  logic [core_cfg_pkg::xlen-1:0] alu_res,
  output logic [core_cfg_pkg::xlen-1:0] pc,
  output logic [core_cfg_pkg::xlen-1:0] snpc,
  output logic                          run,
  output logic                          halted
);
  import rv_isa_pkg::*;
  import core_cfg_pkg::*;

  core_state_e     state;
  logic [xlen-1:0] br_target;
  logic [xlen-1:0] next_pc;

  assign snpc      = pc + xlen'(inst_len);
  assign br_target = pc + imm;

  always_comb begin
    case (pc_sel)
      pc_alu:    next_pc = {alu_res[xlen-1:1], 1'b0}; // jalr clears bit 0.
      pc_branch: next_pc = br_taken ? br_target : snpc;
      default:   next_pc = snpc;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state <= st_boot;
      pc    <= pc_init;
    end else begin
      case (state)
        st_boot: state <= st_run; // pc holds on this edge.
        st_run: begin
          if (is_ebreak) state <= st_halt; // ebreak keeps its own address.
          else pc <= next_pc;
        end
        default: ;
      endcase
    end
  end

  assign run    = (state == st_run);
  assign halted = (state == st_halt);

  a_pc_aligned: assert property (@(posedge clk) disable iff (!rst_n) pc[1:0] == 2'b00);

endmodule

`default_nettype wire

/* design/register_file.sv */
`timescale 1ns/1ps
`default_nettype none

module register_file (
  input  logic                                clk,
  input  logic                                rst_n,
  input  logic [core_cfg_pkg::reg_addr_w-1:0] rs1_addr,
  input  logic [core_cfg_pkg::reg_addr_w-1:0] rs2_addr,
  input  logic [core_cfg_pkg::reg_addr_w-1:0] rd_addr,
  input  logic                                wen,
  input  logic [core_cfg_pkg::xlen-1:0]       wdata,
  output logic [core_cfg_pkg::xlen-1:0]       rs1_val,
  output logic [core_cfg_pkg::xlen-1:0]       rs2_val
);
  import core_cfg_pkg::*;

  logic [xlen-1:0] regs [0:(1<<reg_addr_w)-1];

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < (1 << reg_addr_w); i++) begin
        regs[i] <= '0;
      end
    end else if (wen && rd_addr != '0) begin // x0 is never written.
      regs[rd_addr] <= wdata;
    end
  end

  assign rs1_val = regs[rs1_addr];
  assign rs2_val = regs[rs2_addr];

  // x0 relies on reset and the dropped writes above.
  a_x0_rs1: assert property (@(posedge clk) disable iff (!rst_n)
    (rs1_addr == '0) |-> (rs1_val == '0));
  a_x0_rs2: assert property (@(posedge clk) disable iff (!rst_n)
    (rs2_addr == '0) |-> (rs2_val == '0));

endmodule

`default_nettype wire

/* design/alu_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module alu_unit (
  input  rv_isa_pkg::a_sel_e            a_sel,
  input  rv_isa_pkg::b_sel_e            b_sel,
  input  rv_isa_pkg::alu_op_e           alu_op,
  input  logic [core_cfg_pkg::xlen-1:0] rs1_val,
  input  logic [core_cfg_pkg::xlen-1:0] rs2_val,
  input  logic [core_cfg_pkg::xlen-1:0] pc,
  input  logic [core_cfg_pkg::xlen-1:0] imm,
  output logic [core_cfg_pkg::xlen-1:0] alu_res,
  output logic                          br_taken
);
  import rv_isa_pkg::*;
  import core_cfg_pkg::*;

  logic [xlen-1:0] op_a;
  logic [xlen-1:0] op_b;
  logic [5:0]      shamt;
  logic            lt_s;
  logic            lt_u;
  logic            eq;

  assign op_a  = (a_sel == a_pc)  ? pc  : rs1_val;
  assign op_b  = (b_sel == b_imm) ? imm : rs2_val;
  assign shamt = op_b[5:0];

  assign lt_s = $signed(op_a) < $signed(op_b);
  assign lt_u = op_a < op_b;

  always_comb begin
    case (alu_op)
      alu_sub:    alu_res = op_a - op_b;
      alu_sll:    alu_res = op_a << shamt;
      alu_slt:    alu_res = {{(xlen-1){1'b0}}, lt_s};
      alu_sltu:   alu_res = {{(xlen-1){1'b0}}, lt_u};
      alu_xor:    alu_res = op_a ^ op_b;
      alu_srl:    alu_res = op_a >> shamt;
      alu_sra:    alu_res = $signed(op_a) >>> shamt;
      alu_or:     alu_res = op_a | op_b;
      alu_and:    alu_res = op_a & op_b;
      alu_pass_b: alu_res = op_b;
      default:    alu_res = op_a + op_b;
    endcase
  end

  // compare works on the registers directly, so it is independent of operand selects.
  assign eq       = (rs1_val == rs2_val);
  assign br_taken = (alu_op == alu_xor) ? !eq : eq; // xor stands for bne.

endmodule

`default_nettype wire

/* design/imm_gen.sv */
`timescale 1ns/1ps
`default_nettype none

module imm_gen (
  input  logic [31:0]                   inst,
  input  rv_isa_pkg::imm_sel_e          imm_sel,
  output logic [core_cfg_pkg::xlen-1:0] imm
);
  import rv_isa_pkg::*;
  import core_cfg_pkg::*;

  logic sign;

  assign sign = inst[31]; // every format takes its sign from bit 31.

  always_comb begin
    case (imm_sel)
      imm_s: imm = {{(xlen-12){sign}}, inst[31:25], inst[11:7]};
      imm_b: begin
        // branch offsets are in half-word units.
        imm = {{(xlen-13){sign}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
      end
      imm_u: imm = {{(xlen-32){sign}}, inst[31:12], 12'b0};
      imm_j: begin
        imm = {{(xlen-21){sign}}, inst[31], inst[19:12], inst[20], inst[30:21],
               1'b0};
      end
      default: imm = {{(xlen-12){sign}}, inst[31:20]}; // I format.
    endcase
  end

endmodule

`default_nettype wire

/* design/inst_decoder.sv */
`timescale 1ns/1ps
`default_nettype none

module inst_decoder (
  input  logic [31:0]          inst,
  input  logic                 run,
  output rv_isa_pkg::alu_op_e  alu_op,
  output rv_isa_pkg::a_sel_e   a_sel,
  output rv_isa_pkg::b_sel_e   b_sel,
  output rv_isa_pkg::wb_sel_e  wb_sel,
  output rv_isa_pkg::pc_sel_e  pc_sel,
  output rv_isa_pkg::imm_sel_e imm_sel,
  output logic                 reg_wen,
  output logic                 mem_wen,
  output logic                 mem_ren,
  output logic                 is_ebreak
);
  import rv_isa_pkg::*;

  opcode_e    opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  logic       shift_ok; // legal upper bits for a 6-bit shift amount.
  logic       reg_ok;
  logic       reg_wen_d;
  logic       mem_wen_d;
  logic       mem_ren_d;

  assign opcode = opcode_e'(inst[6:0]);
  assign funct3 = inst[14:12];
  assign funct7 = inst[31:25];

  assign shift_ok = (inst[31:26] == 6'b000000) ||
                    (inst[31:26] == 6'b010000 && funct3 == f3_srl_sra);
  assign reg_ok   = (funct7 == f7_base) ||
                    (funct7 == f7_alt && (funct3 == f3_add_sub || funct3 == f3_srl_sra));

  // the alternate bit only matters for add/sub and srl/sra.
  function automatic alu_op_e f3_to_alu(input logic [2:0] f3, input logic alt);
    case (f3)
      f3_add_sub: return alt ? alu_sub : alu_add;
      f3_sll:     return alu_sll;
      f3_slt:     return alu_slt;
      f3_sltu:    return alu_sltu;
      f3_xor:     return alu_xor;
      f3_srl_sra: return alt ? alu_sra : alu_srl;
      f3_or:      return alu_or;
      default:    return alu_and;
    endcase
  endfunction

  always_comb begin
    alu_op    = alu_add;
    a_sel     = a_rs1;
    b_sel     = b_imm;
    wb_sel    = wb_alu;
    pc_sel    = pc_snpc;
    imm_sel   = imm_i;
    reg_wen_d = 1'b0;
    mem_wen_d = 1'b0;
    mem_ren_d = 1'b0;
    is_ebreak = 1'b0;
    case (opcode)
      op_lui: begin
        imm_sel   = imm_u;
        alu_op    = alu_pass_b;
        reg_wen_d = 1'b1;
      end
      op_auipc: begin
        imm_sel   = imm_u;
        a_sel     = a_pc;
        reg_wen_d = 1'b1;
      end
      op_jal: begin
        imm_sel   = imm_j;
        a_sel     = a_pc; // target is pc + imm through the ALU.
        wb_sel    = wb_snpc;
        pc_sel    = pc_alu;
        reg_wen_d = 1'b1;
      end
      op_jalr: begin
        wb_sel    = wb_snpc;
        pc_sel    = pc_alu;
        reg_wen_d = 1'b1;
      end
      op_branch: begin
        if (funct3 == f3_beq || funct3 == f3_bne) begin
          imm_sel = imm_b;
          b_sel   = b_rs2;
          pc_sel  = pc_branch;
          alu_op  = (funct3 == f3_bne) ? alu_xor : alu_sub; // picks the compare sense.
        end
      end
      op_load: begin
        if (funct3 == f3_dword) begin
          wb_sel    = wb_mem;
          reg_wen_d = 1'b1;
          mem_ren_d = 1'b1;
        end
      end
      op_store: begin
        if (funct3 == f3_dword) begin
          imm_sel   = imm_s;
          mem_wen_d = 1'b1;
        end
      end
      op_imm: begin
        if (funct3 == f3_sll || funct3 == f3_srl_sra) begin
          alu_op    = f3_to_alu(funct3, inst[30]);
          reg_wen_d = shift_ok;
        end else begin
          alu_op    = f3_to_alu(funct3, 1'b0); // addi has no subtract form.
          reg_wen_d = 1'b1;
        end
      end
      op_reg: begin
        b_sel     = b_rs2;
        alu_op    = f3_to_alu(funct3, funct7[5]);
        reg_wen_d = reg_ok;
      end
      op_system: is_ebreak = (inst == ebreak_inst);
      default: ;
    endcase

    // nothing is written outside run state.
    reg_wen = run & reg_wen_d;
    mem_wen = run & mem_wen_d;
    mem_ren = run & mem_ren_d;
  end

endmodule

`default_nettype wire

/* design/core_cfg_pkg.sv */
`default_nettype none

package core_cfg_pkg;

  localparam int xlen       = 64;
  localparam int reg_addr_w = 5;

  localparam logic [xlen-1:0] pc_init = 64'h8000_0000;
  localparam int inst_len = 4; // byte step between instructions.

  // boot lasts one clock after reset so the first fetch is stable.
  typedef enum logic [1:0] {
    st_boot,
    st_run,
    st_halt
  } core_state_e;

endpackage

`default_nettype wire

/* design/rv_isa_pkg.sv */
`default_nettype none

package rv_isa_pkg;

  // major opcodes are taken from inst[6:0].
  typedef enum logic [6:0] {
    op_lui    = 7'b0110111,
    op_auipc  = 7'b0010111,
    op_jal    = 7'b1101111,
    op_jalr   = 7'b1100111,
    op_branch = 7'b1100011,
    op_load   = 7'b0000011,
    op_store  = 7'b0100011,
    op_imm    = 7'b0010011,
    op_reg    = 7'b0110011,
    op_system = 7'b1110011
  } opcode_e;

  typedef enum logic [3:0] {
    alu_add, alu_sub, alu_sll, alu_slt, alu_sltu, alu_xor,
    alu_srl, alu_sra, alu_or, alu_and, alu_pass_b
  } alu_op_e;

  typedef enum logic [2:0] {imm_i, imm_s, imm_b, imm_u, imm_j} imm_sel_e;
  typedef enum logic {a_rs1, a_pc} a_sel_e;
  typedef enum logic {b_rs2, b_imm} b_sel_e;
  typedef enum logic [1:0] {wb_alu, wb_mem, wb_snpc} wb_sel_e;
  typedef enum logic [1:0] {pc_snpc, pc_alu, pc_branch} pc_sel_e;

  localparam logic [2:0] f3_beq     = 3'b000;
  localparam logic [2:0] f3_bne     = 3'b001;
  localparam logic [2:0] f3_dword   = 3'b011; // ld and sd.
  localparam logic [2:0] f3_add_sub = 3'b000;
  localparam logic [2:0] f3_sll     = 3'b001;
  localparam logic [2:0] f3_slt     = 3'b010;
  localparam logic [2:0] f3_sltu    = 3'b011;
  localparam logic [2:0] f3_xor     = 3'b100;
  localparam logic [2:0] f3_srl_sra = 3'b101;
  localparam logic [2:0] f3_or      = 3'b110;
  localparam logic [2:0] f3_and     = 3'b111;

  localparam logic [6:0] f7_base = 7'b0000000;
  localparam logic [6:0] f7_alt  = 7'b0100000; // marks sub and sra.

  localparam logic [31:0] ebreak_inst = 32'h0010_0073;

endpackage

`default_nettype wire
